// File: hw/skdecode_defines.svh
// Secret-key decoder constants for t0 field unpacking and the coefficient store
`ifndef SKDECODE_DEFINES_SVH
`define SKDECODE_DEFINES_SVH

// ----------------------------------------------------------------------
// Field and coefficient geometry
// ----------------------------------------------------------------------

// Width of one packed t0 field, which is the Dilithium parameter d
`define SKD_FIELD_W 13

// Coefficients are stored as 24-bit words, one bit wider than q needs
`define SKD_COEFF_W 24

// The Dilithium modulus q = 2^23 - 2^13 + 1
`define SKD_Q 8380417

// Four t0 fields are packed into one 52-bit host word
`define SKD_FIELDS_PER_WORD 4

// ----------------------------------------------------------------------
// Coefficient memory geometry
// ----------------------------------------------------------------------
`define SKD_MEM_DEPTH 256
`define SKD_ADDR_W 8

`endif

// File: hw/skdecode_pkg.sv
// Shared types for the t0 unpacking subsystem: data widths, opcodes and FSM states
`default_nettype none

package skdecode_pkg;

    `include "skdecode_defines.svh"

    // ----------------------------------------------------------------------
    // Data types
    // ----------------------------------------------------------------------
    typedef logic [`SKD_COEFF_W-1:0] coeff_t;
    typedef logic [`SKD_ADDR_W-1:0] addr_t;
    typedef logic [`SKD_FIELD_W-1:0] field_t;
    typedef logic [`SKD_FIELD_W*`SKD_FIELDS_PER_WORD-1:0] word_t;

    // Decoding operation applied to every field of a word
    typedef enum logic {
        T0_SUB = 1'b0,
        T0_ADD = 1'b1
    } op_e;

    // Unpack sequencer states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        FEED  = 2'd1,
        DRAIN = 2'd2
    } seq_state_e;

endpackage

`default_nettype wire

// File: hw/coeff_mem_if.sv
// Request path from one requester to the coefficient memory arbiter
`default_nettype none
`timescale 1ns/1ps

interface coeff_mem_if;

    // Request side, held steady by the requester until gnt is seen high
    logic                 req;
    logic                 we;
    skdecode_pkg::addr_t  addr;
    skdecode_pkg::coeff_t wdata;

    // Grant and read return, driven by the arbiter
    // Read data is valid on the cycle after the grant
    logic                 gnt;
    skdecode_pkg::coeff_t rdata;

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata
    );

endinterface

`default_nettype wire

// File: hw/skdecode_t0_unpack.sv
// Two-stage modular add/subtract that maps a 13-bit t0 field to a coefficient mod q
`default_nettype none
`timescale 1ns/1ps
`include "skdecode_defines.svh"

module skdecode_t0_unpack (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  zeroize_i,
    input  wire                  enable_i,
    input  skdecode_pkg::op_e    op_i,
    input  skdecode_pkg::field_t field_i,
    output skdecode_pkg::coeff_t coeff_o,
    output logic                 valid_o
);

    // The arithmetic runs on 23 bits since q < 2^23, and the top bit is zero
    localparam int unsigned SUM_W = `SKD_COEFF_W - 1;
    localparam logic [SUM_W-1:0] T0_OFFSET = 1 << (`SKD_FIELD_W - 1);
    localparam logic [SUM_W-1:0] Q_VAL = `SKD_Q;

    logic              is_sub;
    logic [SUM_W-1:0]  field_ext;
    logic [SUM_W-1:0]  opb0;
    logic [SUM_W-1:0]  sum0;
    logic              carry0;
    logic [SUM_W-1:0]  sum0_q;
    logic              carry0_q;
    skdecode_pkg::op_e op_q;
    logic [SUM_W-1:0]  opb1;
    logic              cin1;
    logic [SUM_W-1:0]  sum1;
    logic              carry1;
    logic [SUM_W-1:0]  result;

    // ----------------------------------------------------------------------
    // Stage 1: 2^12 + a, or 2^12 - a as 2^12 + ~a + 1
    // ----------------------------------------------------------------------
    assign is_sub    = (op_i == skdecode_pkg::T0_SUB);
    assign field_ext = SUM_W'(field_i);
    assign opb0      = is_sub ? ~field_ext : field_ext;

    // A carry out on subtract means a <= 2^12, so the difference is not negative
    assign {carry0, sum0} = {1'b0, T0_OFFSET} + {1'b0, opb0} + (SUM_W + 1)'(is_sub);

    always_ff @(posedge clk) begin
        if (enable_i) begin
            sum0_q   <= sum0;
            carry0_q <= carry0;
            op_q     <= op_i;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_o <= 1'b0;
        end else if (zeroize_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= enable_i;
        end
    end

    // ----------------------------------------------------------------------
    // Stage 2: correction by +q on subtract or -q on add
    // ----------------------------------------------------------------------
    assign opb1 = (op_q == skdecode_pkg::T0_SUB) ? Q_VAL : ~Q_VAL;
    assign cin1 = (op_q == skdecode_pkg::T0_ADD);

    assign {carry1, sum1} = {1'b0, sum0_q} + {1'b0, opb1} + (SUM_W + 1)'(cin1);

    // On subtract a negative stage-1 result takes the +q sum
    // On add the -q sum is kept only when it did not borrow
    always_comb begin
        if (op_q == skdecode_pkg::T0_SUB) begin
            result = carry0_q ? sum0_q : sum1;
        end else begin
            result = (carry0_q ^ carry1) ? sum1 : sum0_q;
        end
    end

    assign coeff_o = {1'b0, result};

endmodule

`default_nettype wire

// File: hw/t0_unpack_seq.sv
// Unpack sequencer that feeds the four fields of a word through the t0 datapath into memory
`default_nettype none
`timescale 1ns/1ps
`include "skdecode_defines.svh"

module t0_unpack_seq (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  zeroize_i,
    input  wire                  word_valid_i,
    input  skdecode_pkg::word_t  word_i,
    input  skdecode_pkg::op_e    op_i,
    input  skdecode_pkg::addr_t  base_addr_i,
    output logic                 busy_o,
    coeff_mem_if.requester       mem
);

    localparam int unsigned CNT_W = $clog2(`SKD_FIELDS_PER_WORD);
    localparam logic [CNT_W-1:0] LAST_FIELD = CNT_W'(`SKD_FIELDS_PER_WORD - 1);

    skdecode_pkg::seq_state_e state_q;
    skdecode_pkg::word_t      word_q;
    skdecode_pkg::op_e        op_q;
    skdecode_pkg::addr_t      base_q;
    logic [CNT_W-1:0]         feed_cnt_q;
    logic [CNT_W-1:0]         wr_cnt_q;
    logic                     accept;
    logic                     feed_en;
    skdecode_pkg::field_t     feed_field;
    skdecode_pkg::coeff_t     unpack_coeff;
    logic                     unpack_valid;
    logic                     wr_done;

    // A word is only taken while the sequencer is idle
    assign accept  = (state_q == skdecode_pkg::IDLE) && word_valid_i;
    assign busy_o  = (state_q != skdecode_pkg::IDLE);
    assign wr_done = mem.req && mem.gnt;

    // ----------------------------------------------------------------------
    // Control FSM
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q    <= skdecode_pkg::IDLE;
            feed_cnt_q <= '0;
            wr_cnt_q   <= '0;
        end else if (zeroize_i) begin
            state_q    <= skdecode_pkg::IDLE;
            feed_cnt_q <= '0;
            wr_cnt_q   <= '0;
        end else begin
            // Each granted write moves to the next coefficient address
            if (wr_done) begin
                wr_cnt_q <= wr_cnt_q + 1'b1;
            end
            case (state_q)
                skdecode_pkg::IDLE: begin
                    if (word_valid_i) begin
                        state_q    <= skdecode_pkg::FEED;
                        feed_cnt_q <= '0;
                        wr_cnt_q   <= '0;
                    end
                end
                skdecode_pkg::FEED: begin
                    feed_cnt_q <= feed_cnt_q + 1'b1;
                    if (feed_cnt_q == LAST_FIELD) begin
                        state_q <= skdecode_pkg::DRAIN;
                    end
                end
                skdecode_pkg::DRAIN: begin
                    // Done once the last coefficient has been written
                    if (wr_done && (wr_cnt_q == LAST_FIELD)) begin
                        state_q <= skdecode_pkg::IDLE;
                    end
                end
                default: state_q <= skdecode_pkg::IDLE;
            endcase
        end
    end

    // The word, opcode and base address stay put for the whole sequence
    always_ff @(posedge clk) begin
        if (accept) begin
            word_q <= word_i;
            op_q   <= op_i;
            base_q <= base_addr_i;
        end
    end

    // ----------------------------------------------------------------------
    // Datapath and memory write port
    // ----------------------------------------------------------------------
    // Lowest field first, one per cycle
    assign feed_en    = (state_q == skdecode_pkg::FEED);
    assign feed_field = word_q[feed_cnt_q * `SKD_FIELD_W +: `SKD_FIELD_W];

    skdecode_t0_unpack u_unpack (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .enable_i  (feed_en),
        .op_i      (op_q),
        .field_i   (feed_field),
        .coeff_o   (unpack_coeff),
        .valid_o   (unpack_valid)
    );

    // The sequencer has priority, so a request is granted on the cycle it appears
    assign mem.req   = unpack_valid;
    assign mem.we    = 1'b1;
    assign mem.addr  = base_q + skdecode_pkg::addr_t'(wr_cnt_q);
    assign mem.wdata = unpack_coeff;

endmodule

`default_nettype wire

// File: hw/coeff_readback.sv
// Host readback port that holds one read request until granted and returns the stored coefficient
`default_nettype none
`timescale 1ns/1ps

module coeff_readback (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  zeroize_i,
    input  wire                  rd_req_i,
    input  skdecode_pkg::addr_t  rd_addr_i,
    output logic                 rd_valid_o,
    output skdecode_pkg::coeff_t rd_data_o,
    coeff_mem_if.requester       mem
);

    logic                pending_q;
    skdecode_pkg::addr_t addr_q;

    // Pending flag and the return strobe, which marks the cycle after the grant
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            pending_q  <= 1'b0;
            rd_valid_o <= 1'b0;
        end else if (zeroize_i) begin
            pending_q  <= 1'b0;
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= pending_q && mem.gnt;
            if (!pending_q) begin
                pending_q <= rd_req_i;
            end else if (mem.gnt) begin
                pending_q <= 1'b0;
            end
        end
    end

    // New requests are dropped while one is still waiting
    always_ff @(posedge clk) begin
        if (!pending_q && rd_req_i) begin
            addr_q <= rd_addr_i;
        end
    end

    assign mem.req   = pending_q;
    assign mem.we    = 1'b0;
    assign mem.addr  = addr_q;
    assign mem.wdata = '0;

    // The RAM read register holds the word on the rd_valid_o cycle
    assign rd_data_o = mem.rdata;

endmodule

`default_nettype wire

// File: hw/coeff_mem_arbiter.sv
// Fixed-priority arbiter sharing the single-port coefficient RAM between sequencer and readback
`default_nettype none
`timescale 1ns/1ps

module coeff_mem_arbiter (
    input  wire                  clk,
    input  wire                  reset_n,
    coeff_mem_if.arbiter         seq_port,
    coeff_mem_if.arbiter         rd_port,
    output logic                 mem_en_o,
    output logic                 mem_we_o,
    output skdecode_pkg::addr_t  mem_addr_o,
    output skdecode_pkg::coeff_t mem_wdata_o,
    input  skdecode_pkg::coeff_t mem_rdata_i
);

    logic seq_gnt;
    logic rd_gnt;
    logic rd_read_q;

    // ----------------------------------------------------------------------
    // Grant and request mux
    // ----------------------------------------------------------------------
    // The sequencer always wins, so it is never stalled
    assign seq_gnt = seq_port.req;
    assign rd_gnt  = rd_port.req && !seq_port.req;

    assign seq_port.gnt = seq_gnt;
    assign rd_port.gnt  = rd_gnt;

    assign mem_en_o    = seq_port.req || rd_port.req;
    assign mem_we_o    = seq_gnt ? seq_port.we : rd_port.we;
    assign mem_addr_o  = seq_gnt ? seq_port.addr : rd_port.addr;
    assign mem_wdata_o = seq_gnt ? seq_port.wdata : rd_port.wdata;

    // ----------------------------------------------------------------------
    // Read return steering
    // ----------------------------------------------------------------------
    // Remember a granted readback read for the cycle the data comes back
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_read_q <= 1'b0;
        end else begin
            rd_read_q <= rd_gnt && !rd_port.we;
        end
    end

    // The sequencer only writes, so read data goes to the readback port alone
    assign seq_port.rdata = '0;
    assign rd_port.rdata  = rd_read_q ? mem_rdata_i : '0;

endmodule

`default_nettype wire

// File: hw/coeff_mem.sv
// Single-port coefficient RAM, 256 words of 24 bits with a registered read
`default_nettype none
`timescale 1ns/1ps
`include "skdecode_defines.svh"

module coeff_mem (
    input  wire                  clk,
    input  wire                  en_i,
    input  wire                  we_i,
    input  skdecode_pkg::addr_t  addr_i,
    input  skdecode_pkg::coeff_t wdata_i,
    output skdecode_pkg::coeff_t rdata_o
);

    skdecode_pkg::coeff_t mem_q [0:`SKD_MEM_DEPTH-1];

    // A read shows up on rdata_o one cycle after the enabled access
    // Writes leave rdata_o holding its last read value
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/skdecode_top.sv
// Top level of the t0 unpacking subsystem with sequencer, readback port, arbiter and RAM
`default_nettype none
`timescale 1ns/1ps

module skdecode_top (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  zeroize_i,
    input  wire                  word_valid_i,
    input  skdecode_pkg::word_t  word_i,
    input  skdecode_pkg::op_e    op_i,
    input  skdecode_pkg::addr_t  base_addr_i,
    output logic                 busy_o,
    input  wire                  rd_req_i,
    input  skdecode_pkg::addr_t  rd_addr_i,
    output logic                 rd_valid_o,
    output skdecode_pkg::coeff_t rd_data_o
);

    // RAM side of the arbiter
    logic                 mem_en;
    logic                 mem_we;
    skdecode_pkg::addr_t  mem_addr;
    skdecode_pkg::coeff_t mem_wdata;
    skdecode_pkg::coeff_t mem_rdata;

    // One request path per memory client
    coeff_mem_if seq_mem ();
    coeff_mem_if rd_mem ();

    // ----------------------------------------------------------------------
    // Memory clients
    // ----------------------------------------------------------------------
    t0_unpack_seq u_seq (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .word_valid_i (word_valid_i),
        .word_i       (word_i),
        .op_i         (op_i),
        .base_addr_i  (base_addr_i),
        .busy_o       (busy_o),
        .mem          (seq_mem.requester)
    );

    coeff_readback u_readback (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .rd_req_i   (rd_req_i),
        .rd_addr_i  (rd_addr_i),
        .rd_valid_o (rd_valid_o),
        .rd_data_o  (rd_data_o),
        .mem        (rd_mem.requester)
    );

    // ----------------------------------------------------------------------
    // Shared coefficient storage
    // ----------------------------------------------------------------------
    coeff_mem_arbiter u_arbiter (
        .clk         (clk),
        .reset_n     (reset_n),
        .seq_port    (seq_mem.arbiter),
        .rd_port     (rd_mem.arbiter),
        .mem_en_o    (mem_en),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_rdata_i (mem_rdata)
    );

    coeff_mem u_mem (
        .clk     (clk),
        .en_i    (mem_en),
        .we_i    (mem_we),
        .addr_i  (mem_addr),
        .wdata_i (mem_wdata),
        .rdata_o (mem_rdata)
    );

endmodule

`default_nettype wire

// File: sim/skdecode_tb.sv
// Testbench for the t0 unpacking subsystem, table driven with readback checks against a model
`default_nettype none
`timescale 1ns/1ps
`include "skdecode_defines.svh"

module skdecode_tb;

    localparam int NUM_ENTRIES  = 10;
    localparam int NUM_LOOPED   = 7;
    localparam int BUSY_TIMEOUT = 20;
    localparam int RD_TIMEOUT   = 20;

    // One word to unpack with its four expected coefficients, lowest field in exp[0]
    typedef struct packed {
        skdecode_pkg::word_t         word;
        skdecode_pkg::op_e           op;
        skdecode_pkg::addr_t         base;
        skdecode_pkg::coeff_t [3:0]  exp;
    } entry_t;

    logic                 clk = 1'b0;
    logic                 reset_n;
    logic                 zeroize_i;
    logic                 word_valid_i;
    skdecode_pkg::word_t  word_i;
    skdecode_pkg::op_e    op_i;
    skdecode_pkg::addr_t  base_addr_i;
    logic                 busy_o;
    logic                 rd_req_i;
    skdecode_pkg::addr_t  rd_addr_i;
    logic                 rd_valid_o;
    skdecode_pkg::coeff_t rd_data_o;

    entry_t entries [NUM_ENTRIES];
    int     seed = 84;
    int     errors = 0;
    int     err_mark = 0;
    int     test_count = 0;
    int     fail_count = 0;

    always #5 clk = ~clk;

    skdecode_top dut_i (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize_i    (zeroize_i),
        .word_valid_i (word_valid_i),
        .word_i       (word_i),
        .op_i         (op_i),
        .base_addr_i  (base_addr_i),
        .busy_o       (busy_o),
        .rd_req_i     (rd_req_i),
        .rd_addr_i    (rd_addr_i),
        .rd_valid_o   (rd_valid_o),
        .rd_data_o    (rd_data_o)
    );

    // ----------------------------------------------------------------------
    // Reference model and compare tasks
    // ----------------------------------------------------------------------
    // Subtract wraps below zero by adding q, add never reaches q for 13-bit fields
    function automatic skdecode_pkg::coeff_t t0_model(input skdecode_pkg::op_e op,
                                                      input skdecode_pkg::field_t a);
        if (op == skdecode_pkg::T0_ADD) begin
            return skdecode_pkg::coeff_t'(4096 + a);
        end else if (a <= 4096) begin
            return skdecode_pkg::coeff_t'(4096 - a);
        end
        return skdecode_pkg::coeff_t'(`SKD_Q - (a - 4096));
    endfunction

    task automatic check_coeff(input skdecode_pkg::coeff_t got, input skdecode_pkg::coeff_t exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s read %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_busy(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %0b, expected %0b", $time, what, got, exp);
            errors++;
        end
    endtask

    // Prints the outcome of one test from the errors it added
    task automatic end_test(input string name);
        test_count++;
        if (errors != err_mark) begin
            fail_count++;
            $display("FAIL  %s", name);
        end else begin
            $display("PASS  %s", name);
        end
        err_mark = errors;
    endtask

    // ----------------------------------------------------------------------
    // Stimulus tasks
    // ----------------------------------------------------------------------
    task automatic set_entry(input int idx, input skdecode_pkg::op_e op,
                             input skdecode_pkg::addr_t base,
                             input skdecode_pkg::field_t f0, input skdecode_pkg::field_t f1,
                             input skdecode_pkg::field_t f2, input skdecode_pkg::field_t f3,
                             input skdecode_pkg::coeff_t e0, input skdecode_pkg::coeff_t e1,
                             input skdecode_pkg::coeff_t e2, input skdecode_pkg::coeff_t e3);
        entries[idx].word = {f3, f2, f1, f0};
        entries[idx].op   = op;
        entries[idx].base = base;
        entries[idx].exp  = {e3, e2, e1, e0};
    endtask

    // One-cycle word pulse, busy_o must be up on the cycle after it
    task automatic start_word(input int idx);
        @(posedge clk);
        word_valid_i <= 1'b1;
        word_i       <= entries[idx].word;
        op_i         <= entries[idx].op;
        base_addr_i  <= entries[idx].base;
        @(posedge clk);
        word_valid_i <= 1'b0;
        @(negedge clk);
        check_busy(busy_o, 1'b1, $sformatf("busy_o after word of entry %0d", idx));
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy_o && cycles < BUSY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy_o) begin
            $display("Timeout: busy_o did not fall within %0d cycles", BUSY_TIMEOUT);
            errors++;
        end
    endtask

    // Latency counts the cycles from the request being seen to rd_valid_o
    task automatic read_coeff(input skdecode_pkg::addr_t addr,
                              output skdecode_pkg::coeff_t data, output int cycles);
        @(posedge clk);
        rd_req_i  <= 1'b1;
        rd_addr_i <= addr;
        @(posedge clk);
        rd_req_i  <= 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!rd_valid_o && cycles < RD_TIMEOUT);
        data = rd_data_o;
        if (!rd_valid_o) begin
            $display("Timeout: rd_valid_o never rose for the read of address %0d", addr);
            errors++;
        end
    endtask

    task automatic check_entry(input int idx);
        skdecode_pkg::coeff_t data;
        int                   lat;
        for (int k = 0; k < `SKD_FIELDS_PER_WORD; k++) begin
            read_coeff(skdecode_pkg::addr_t'(entries[idx].base + k), data, lat);
            check_coeff(data, entries[idx].exp[k], $sformatf("entry %0d field %0d", idx, k));
        end
    endtask

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial begin
        skdecode_pkg::field_t fld [4];
        skdecode_pkg::op_e    rop;
        skdecode_pkg::coeff_t data;
        int                   lat;

        reset_n      = 1'b0;
        zeroize_i    = 1'b0;
        word_valid_i = 1'b0;
        word_i       = '0;
        op_i         = skdecode_pkg::T0_SUB;
        base_addr_i  = '0;
        rd_req_i     = 1'b0;
        rd_addr_i    = '0;

        // Edge values on subtract, 4097 and 8191 wrap to q minus the difference
        set_entry(0, skdecode_pkg::T0_SUB, 8'h10, 0, 4096, 4097, 8191, 4096, 0, 8380416, 8376322);
        set_entry(1, skdecode_pkg::T0_ADD, 8'h20, 0, 1, 4096, 8191, 4096, 4097, 8192, 12287);
        set_entry(2, skdecode_pkg::T0_SUB, 8'h30, 1, 100, 5000, 4095, 4095, 3996, 8379513, 1);
        for (int i = 3; i < NUM_LOOPED; i++) begin
            for (int k = 0; k < 4; k++) begin
                fld[k] = skdecode_pkg::field_t'($random(seed));
            end
            rop = ($random(seed) & 1) ? skdecode_pkg::T0_ADD : skdecode_pkg::T0_SUB;
            set_entry(i, rop, skdecode_pkg::addr_t'(8'h80 + 4 * i),
                      fld[0], fld[1], fld[2], fld[3],
                      t0_model(rop, fld[0]), t0_model(rop, fld[1]),
                      t0_model(rop, fld[2]), t0_model(rop, fld[3]));
        end
        set_entry(7, skdecode_pkg::T0_ADD, 8'h40, 10, 20, 30, 40, 4106, 4116, 4126, 4136);
        set_entry(8, skdecode_pkg::T0_SUB, 8'h50, 2, 3, 4, 5, 4094, 4093, 4092, 4091);
        set_entry(9, skdecode_pkg::T0_SUB, 8'h50, 6000, 7000, 8000, 4100,
                  8378513, 8377513, 8376513, 8380413);

        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_busy(busy_o, 1'b0, "busy_o after reset");
        check_busy(rd_valid_o, 1'b0, "rd_valid_o after reset");
        end_test("reset state");

        for (int i = 0; i < NUM_LOOPED; i++) begin
            start_word(i);
            wait_idle();
            check_entry(i);
            end_test($sformatf("entry %0d", i));
        end

        // A read queued behind the four sequencer writes comes back late but intact
        start_word(7);
        read_coeff(skdecode_pkg::addr_t'(entries[1].base + 2), data, lat);
        check_coeff(data, entries[1].exp[2], "readback during unpack");
        check_busy(lat > 2, 1'b1, "readback delayed behind writes");
        wait_idle();
        check_entry(7);
        end_test("readback during unpack");

        // Zeroize one cycle into a word, then a full word at the same base
        start_word(8);
        @(posedge clk);
        zeroize_i <= 1'b1;
        @(posedge clk);
        zeroize_i <= 1'b0;
        @(negedge clk);
        check_busy(busy_o, 1'b0, "busy_o after zeroize");
        start_word(9);
        wait_idle();
        check_entry(9);
        end_test("zeroize mid-word");

        check_entry(0);
        check_entry(1);
        end_test("earlier words unchanged");

        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 test_count, fail_count, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+hw
hw/skdecode_pkg.sv
hw/coeff_mem_if.sv
hw/skdecode_t0_unpack.sv
hw/t0_unpack_seq.sv
hw/coeff_readback.sv
hw/coeff_mem_arbiter.sv
hw/coeff_mem.sv
hw/skdecode_top.sv
sim/skdecode_tb.sv

// File: Bender.yml
package:
  name: skdecode

sources:
  - include_dirs:
      - hw
    files:
      - hw/skdecode_pkg.sv
      - hw/coeff_mem_if.sv
      - hw/skdecode_t0_unpack.sv
      - hw/t0_unpack_seq.sv
      - hw/coeff_readback.sv
      - hw/coeff_mem_arbiter.sv
      - hw/coeff_mem.sv
      - hw/skdecode_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/skdecode_tb.sv
